//--- Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
RTL_TOP   ?= soc_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Done: errors found" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation FAILED"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
source/soc_pkg.sv
source/jtag_dbg_tap.sv
source/uart_cmd_bridge.sv
source/bus_arbiter.sv
source/periph_regs.sv
source/soc_top.sv
testbench/soc_checker.sv
testbench/soc_monitor.sv
testbench/soc_tb.sv

//--- source/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              arst_n_i,
  input  logic              dbg_req_i,
  input  logic              dbg_we_i,
  input  logic [ADDR_W-1:0] dbg_addr_i,
  input  logic [DATA_W-1:0] dbg_wdata_i,
  input  logic              uart_req_i,
  input  logic              uart_we_i,
  input  logic [ADDR_W-1:0] uart_addr_i,
  input  logic [DATA_W-1:0] uart_wdata_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  output logic              dbg_gnt_o,
  output logic              uart_gnt_o,
  output logic              dbg_rvalid_o,
  output logic              uart_rvalid_o,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              bus_valid_o,
  output logic              bus_we_o,
  output logic [ADDR_W-1:0] bus_addr_o,
  output logic [DATA_W-1:0] bus_wdata_o
);

  // set when dbg won the last grant
  logic last_dbg_q;
  // read issued last cycle and its owner
  logic rd_pend_q;
  logic rd_dbg_q;

  // same-cycle grant, on contention the master not served last time wins
  assign dbg_gnt_o   = dbg_req_i & (~uart_req_i | ~last_dbg_q);
  assign uart_gnt_o  = uart_req_i & ~dbg_gnt_o;
  assign bus_valid_o = dbg_gnt_o | uart_gnt_o;

  // request fields follow the winner
  assign bus_we_o    = dbg_gnt_o ? dbg_we_i    : uart_we_i;
  assign bus_addr_o  = dbg_gnt_o ? dbg_addr_i  : uart_addr_i;
  assign bus_wdata_o = dbg_gnt_o ? dbg_wdata_i : uart_wdata_i;

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_dbg_q <= 1'b0;
      rd_pend_q  <= 1'b0;
      rd_dbg_q   <= 1'b0;
    end else begin
      if (bus_valid_o) begin
        last_dbg_q <= dbg_gnt_o;
      end
      rd_pend_q <= bus_valid_o & ~bus_we_o;
      rd_dbg_q  <= dbg_gnt_o;
    end
  end

  // read data one cycle after grant, steered to the owner
  assign dbg_rvalid_o  = rd_pend_q & rd_dbg_q;
  assign uart_rvalid_o = rd_pend_q & ~rd_dbg_q;
  assign rd_data_o     = bus_rdata_i;

endmodule

//--- source/jtag_dbg_tap.sv
`timescale 1ns/100ps

module jtag_dbg_tap import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              arst_n_i,
  input  logic              jtag_tck_i,
  input  logic              jtag_tms_i,
  input  logic              jtag_tdi_i,
  input  logic              dbg_gnt_i,
  input  logic              dbg_rvalid_i,
  input  logic [DATA_W-1:0] rd_data_i,
  output logic              jtag_tdo_o,
  output logic              dbg_req_o,
  output logic              dbg_we_o,
  output logic [ADDR_W-1:0] dbg_addr_o,
  output logic [DATA_W-1:0] dbg_wdata_o
);

  typedef enum logic [3:0] {
    TLR, RTI, SEL_DR, CAP_DR, SH_DR, EX1_DR, PA_DR, EX2_DR,
    UPD_DR, SEL_IR, CAP_IR, SH_IR, EX1_IR, PA_IR, EX2_IR, UPD_IR
  } tap_state_t;

  tap_state_t state_q;
  tap_state_t state_d;
  // bit 2 tck, bit 1 tms, bit 0 tdi
  logic [2:0] sync1_q;
  logic [2:0] sync2_q;
  logic tck_prev_q;
  logic tck_rise;
  logic tck_fall;
  logic tms;
  logic tdi;
  logic [IR_W-1:0] ir_q;
  logic [IR_W-1:0] ir_shift_q;
  logic [31:0] dr_q;
  logic [DATA_W-1:0] dbg_rdata_q;
  logic busy_q;
  logic [1:0] upd_op;
  logic start_acc;

  // two-flop sync of all jtag pins together keeps tms/tdi aligned to tck
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      tck_prev_q <= 1'b0;
    end else begin
      sync1_q    <= {jtag_tck_i, jtag_tms_i, jtag_tdi_i};
      sync2_q    <= sync1_q;
      tck_prev_q <= sync2_q[2];
    end
  end

  assign tms      = sync2_q[1];
  assign tdi      = sync2_q[0];
  assign tck_rise = sync2_q[2] & ~tck_prev_q;
  assign tck_fall = ~sync2_q[2] & tck_prev_q;

  // standard 1149.1 state graph
  always_comb begin
    case (state_q)
      TLR:     state_d = tms ? TLR    : RTI;
      RTI:     state_d = tms ? SEL_DR : RTI;
      SEL_DR:  state_d = tms ? SEL_IR : CAP_DR;
      CAP_DR:  state_d = tms ? EX1_DR : SH_DR;
      SH_DR:   state_d = tms ? EX1_DR : SH_DR;
      EX1_DR:  state_d = tms ? UPD_DR : PA_DR;
      PA_DR:   state_d = tms ? EX2_DR : PA_DR;
      EX2_DR:  state_d = tms ? UPD_DR : SH_DR;
      UPD_DR:  state_d = tms ? SEL_DR : RTI;
      SEL_IR:  state_d = tms ? TLR    : CAP_IR;
      CAP_IR:  state_d = tms ? EX1_IR : SH_IR;
      SH_IR:   state_d = tms ? EX1_IR : SH_IR;
      EX1_IR:  state_d = tms ? UPD_IR : PA_IR;
      PA_IR:   state_d = tms ? EX2_IR : PA_IR;
      EX2_IR:  state_d = tms ? UPD_IR : SH_IR;
      UPD_IR:  state_d = tms ? SEL_DR : RTI;
      default: state_d = TLR;
    endcase
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= TLR;
      ir_q       <= IR_IDCODE;
      jtag_tdo_o <= 1'b0;
    end else begin
      if (tck_rise) begin
        state_q <= state_d;
      end
      // reset state forces idcode, update-ir loads on falling tck
      if (state_q == TLR) begin
        ir_q <= IR_IDCODE;
      end else if (tck_fall && state_q == UPD_IR) begin
        ir_q <= ir_shift_q;
      end
      // tdo launched on falling tck, quiet outside shift states
      if (tck_fall) begin
        case (state_q)
          SH_DR:   jtag_tdo_o <= dr_q[0];
          SH_IR:   jtag_tdo_o <= ir_shift_q[0];
          default: jtag_tdo_o <= 1'b0;
        endcase
      end
    end
  end

  // capture and shift on rising tck
  always_ff @(posedge clock_i) begin
    if (tck_rise) begin
      case (state_q)
        CAP_IR: ir_shift_q <= IR_W'(1);
        SH_IR:  ir_shift_q <= {tdi, ir_shift_q[IR_W-1:1]};
        CAP_DR: begin
          case (ir_q)
            IR_IDCODE: dr_q <= JTAG_IDCODE;
            IR_DBG:    dr_q <= 32'({dbg_addr_o, dbg_rdata_q, busy_q ? DBG_OP_BUSY : DBG_OP_NONE});
            default:   dr_q <= '0;
          endcase
        end
        SH_DR: begin
          // chain length follows the selected instruction
          case (ir_q)
            IR_IDCODE: dr_q <= {tdi, dr_q[31:1]};
            IR_DBG:    dr_q[DBG_W-1:0] <= {tdi, dr_q[DBG_W-1:1]};
            default:   dr_q[0] <= tdi;
          endcase
        end
        default: ;
      endcase
    end
  end

  // update-dr of the debug register starts one access unless one is in flight
  assign upd_op    = dr_q[1:0];
  assign start_acc = tck_fall && (state_q == UPD_DR) && (ir_q == IR_DBG) &&
                     (upd_op != DBG_OP_NONE) && !busy_q;

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dbg_req_o   <= 1'b0;
      dbg_we_o    <= 1'b0;
      dbg_addr_o  <= '0;
      dbg_wdata_o <= '0;
      dbg_rdata_q <= '0;
      busy_q      <= 1'b0;
    end else if (start_acc) begin
      dbg_req_o   <= 1'b1;
      dbg_we_o    <= (upd_op == DBG_OP_WRITE);
      dbg_addr_o  <= dr_q[DBG_W-1 -: ADDR_W];
      dbg_wdata_o <= dr_q[2 +: DATA_W];
      busy_q      <= 1'b1;
    end else begin
      // write done at grant, read done at rvalid
      if (dbg_gnt_i) begin
        dbg_req_o <= 1'b0;
        if (dbg_we_o) begin
          busy_q <= 1'b0;
        end
      end
      if (dbg_rvalid_i) begin
        dbg_rdata_q <= rd_data_i;
        busy_q      <= 1'b0;
      end
    end
  end

endmodule

//--- source/periph_regs.sv
`timescale 1ns/100ps

module periph_regs import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              arst_n_i,
  input  logic              bus_valid_i,
  input  logic              bus_we_i,
  input  logic [ADDR_W-1:0] bus_addr_i,
  input  logic [DATA_W-1:0] bus_wdata_i,
  input  logic [DATA_W-1:0] gpio_i,
  output logic [DATA_W-1:0] bus_rdata_o,
  output logic [DATA_W-1:0] gpio_o,
  output logic              pwm_o
);

  logic [DATA_W-1:0] gpio_meta_q;
  logic [DATA_W-1:0] gpio_in_q;
  logic [DATA_W-1:0] period_q;
  logic [DATA_W-1:0] duty_q;
  logic [DATA_W-1:0] cnt_q;
  logic [DATA_W-1:0] rd_mux;

  // gpio input synchronizer
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_meta_q <= '0;
      gpio_in_q   <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_in_q   <= gpio_meta_q;
    end
  end

  // writable registers, gpio_in and id silently ignore writes
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_o   <= '0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (bus_valid_i && bus_we_i) begin
      case (bus_addr_i)
        REG_GPIO_OUT:   gpio_o   <= bus_wdata_i;
        REG_PWM_PERIOD: period_q <= bus_wdata_i;
        REG_PWM_DUTY:   duty_q   <= bus_wdata_i;
        default: ;
      endcase
    end
  end

  // read select, unmapped reads as zero
  always_comb begin
    case (bus_addr_i)
      REG_GPIO_OUT:   rd_mux = gpio_o;
      REG_GPIO_IN:    rd_mux = gpio_in_q;
      REG_PWM_PERIOD: rd_mux = period_q;
      REG_PWM_DUTY:   rd_mux = duty_q;
      REG_ID:         rd_mux = SOC_ID;
      default:        rd_mux = '0;
    endcase
  end

  // read data registered one cycle after the request
  always_ff @(posedge clock_i) begin
    if (bus_valid_i && !bus_we_i) begin
      bus_rdata_o <= rd_mux;
    end
  end

  // pwm counter 0..period then wrap
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      pwm_o <= 1'b0;
    end else begin
      if (cnt_q >= period_q) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      // high for duty counts out of period+1
      pwm_o <= (cnt_q < duty_q);
    end
  end

endmodule

//--- source/soc_pkg.sv
package soc_pkg;

  // register bus geometry
  localparam int ADDR_W = 4;
  localparam int DATA_W = 16;

  // register map
  localparam logic [ADDR_W-1:0] REG_GPIO_OUT   = 4'd0;
  localparam logic [ADDR_W-1:0] REG_GPIO_IN    = 4'd1;
  localparam logic [ADDR_W-1:0] REG_PWM_PERIOD = 4'd2;
  localparam logic [ADDR_W-1:0] REG_PWM_DUTY   = 4'd3;
  localparam logic [ADDR_W-1:0] REG_ID         = 4'd4;

  // read-only identity word
  localparam logic [DATA_W-1:0] SOC_ID = 16'h5C17;

  // version, part number, manufacturer, fixed one
  localparam logic [31:0] JTAG_IDCODE = {4'h1, 16'h5C01, 11'h2A5, 1'b1};

  // tap instruction register
  localparam int IR_W = 5;
  localparam logic [IR_W-1:0] IR_IDCODE = 5'd1;
  localparam logic [IR_W-1:0] IR_DBG    = 5'd17;
  localparam logic [IR_W-1:0] IR_BYPASS = 5'd31;

  // debug access register, {addr, data, op}
  localparam int DBG_W = 22;
  localparam logic [1:0] DBG_OP_NONE  = 2'd0;
  localparam logic [1:0] DBG_OP_READ  = 2'd1;
  localparam logic [1:0] DBG_OP_WRITE = 2'd2;
  localparam logic [1:0] DBG_OP_BUSY  = 2'd3;

  // uart bit timing
  localparam int UART_DIV   = 8;
  localparam int UART_CNT_W = $clog2(UART_DIV);

endpackage

//--- source/soc_top.sv
`timescale 1ns/100ps

module soc_top import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              arst_n_i,
  input  logic [DATA_W-1:0] gpio_i,
  output logic [DATA_W-1:0] gpio_o,
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  output logic              pwm_o,
  input  logic              jtag_tck_i,
  input  logic              jtag_tms_i,
  input  logic              jtag_tdi_i,
  output logic              jtag_tdo_o
);

  // debug tap master
  logic              dbg_req;
  logic              dbg_we;
  logic [ADDR_W-1:0] dbg_addr;
  logic [DATA_W-1:0] dbg_wdata;
  logic              dbg_gnt;
  logic              dbg_rvalid;
  // uart bridge master
  logic              uart_req;
  logic              uart_we;
  logic [ADDR_W-1:0] uart_addr;
  logic [DATA_W-1:0] uart_wdata;
  logic              uart_gnt;
  logic              uart_rvalid;
  // shared read data and peripheral side
  logic [DATA_W-1:0] rd_data;
  logic              bus_valid;
  logic              bus_we;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic [DATA_W-1:0] bus_rdata;

  jtag_dbg_tap u_tap (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .jtag_tck_i   (jtag_tck_i),
    .jtag_tms_i   (jtag_tms_i),
    .jtag_tdi_i   (jtag_tdi_i),
    .dbg_gnt_i    (dbg_gnt),
    .dbg_rvalid_i (dbg_rvalid),
    .rd_data_i    (rd_data),
    .jtag_tdo_o   (jtag_tdo_o),
    .dbg_req_o    (dbg_req),
    .dbg_we_o     (dbg_we),
    .dbg_addr_o   (dbg_addr),
    .dbg_wdata_o  (dbg_wdata)
  );

  uart_cmd_bridge u_bridge (
    .clock_i       (clock_i),
    .arst_n_i      (arst_n_i),
    .uart_rx_i     (uart_rx_i),
    .uart_gnt_i    (uart_gnt),
    .uart_rvalid_i (uart_rvalid),
    .rd_data_i     (rd_data),
    .uart_tx_o     (uart_tx_o),
    .uart_req_o    (uart_req),
    .uart_we_o     (uart_we),
    .uart_addr_o   (uart_addr),
    .uart_wdata_o  (uart_wdata)
  );

  bus_arbiter u_arb (
    .clock_i       (clock_i),
    .arst_n_i      (arst_n_i),
    .dbg_req_i     (dbg_req),
    .dbg_we_i      (dbg_we),
    .dbg_addr_i    (dbg_addr),
    .dbg_wdata_i   (dbg_wdata),
    .uart_req_i    (uart_req),
    .uart_we_i     (uart_we),
    .uart_addr_i   (uart_addr),
    .uart_wdata_i  (uart_wdata),
    .bus_rdata_i   (bus_rdata),
    .dbg_gnt_o     (dbg_gnt),
    .uart_gnt_o    (uart_gnt),
    .dbg_rvalid_o  (dbg_rvalid),
    .uart_rvalid_o (uart_rvalid),
    .rd_data_o     (rd_data),
    .bus_valid_o   (bus_valid),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_wdata_o   (bus_wdata)
  );

  periph_regs u_regs (
    .clock_i     (clock_i),
    .arst_n_i    (arst_n_i),
    .bus_valid_i (bus_valid),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .gpio_i      (gpio_i),
    .bus_rdata_o (bus_rdata),
    .gpio_o      (gpio_o),
    .pwm_o       (pwm_o)
  );

endmodule

//--- source/uart_cmd_bridge.sv
`timescale 1ns/100ps

module uart_cmd_bridge import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              arst_n_i,
  input  logic              uart_rx_i,
  input  logic              uart_gnt_i,
  input  logic              uart_rvalid_i,
  input  logic [DATA_W-1:0] rd_data_i,
  output logic              uart_tx_o,
  output logic              uart_req_o,
  output logic              uart_we_o,
  output logic [ADDR_W-1:0] uart_addr_o,
  output logic [DATA_W-1:0] uart_wdata_o
);

  typedef enum logic [2:0] {
    C_IDLE, C_DATA_HI, C_DATA_LO, C_REQ, C_READ, C_TX_HI, C_TX_LO
  } cmd_state_t;

  cmd_state_t cmd_q;
  logic [1:0] rx_sync_q;
  logic rx_busy_q;
  logic rx_valid_q;
  logic [UART_CNT_W-1:0] rx_cnt_q;
  logic [3:0] rx_bit_q;
  logic [7:0] rx_byte_q;
  logic [DATA_W-1:0] resp_q;
  logic tx_busy_q;
  logic tx_load;
  logic [7:0] tx_byte;
  logic [UART_CNT_W-1:0] tx_cnt_q;
  logic [3:0] tx_bit_q;
  logic [9:0] tx_shift_q;

  // receiver, start edge then mid-bit sampling
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync_q  <= 2'b11;
      rx_busy_q  <= 1'b0;
      rx_valid_q <= 1'b0;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_byte_q  <= '0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], uart_rx_i};
      rx_valid_q <= 1'b0;
      if (!rx_busy_q) begin
        if (!rx_sync_q[1]) begin
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= UART_CNT_W'(UART_DIV / 2 - 1);
          rx_bit_q  <= '0;
        end
      end else if (rx_cnt_q != '0) begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
      end else begin
        rx_cnt_q <= UART_CNT_W'(UART_DIV - 1);
        rx_bit_q <= rx_bit_q + 1'b1;
        if (rx_bit_q == 4'd0) begin
          // glitch, start bit gone by mid-bit
          if (rx_sync_q[1]) begin
            rx_busy_q <= 1'b0;
          end
        end else if (rx_bit_q == 4'd9) begin
          // stop bit low means framing error, byte dropped
          rx_busy_q  <= 1'b0;
          rx_valid_q <= rx_sync_q[1];
        end else begin
          rx_byte_q <= {rx_sync_q[1], rx_byte_q[7:1]};
        end
      end
    end
  end

  // command assembler
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_q        <= C_IDLE;
      uart_we_o    <= 1'b0;
      uart_addr_o  <= '0;
      uart_wdata_o <= '0;
      resp_q       <= '0;
    end else begin
      case (cmd_q)
        C_IDLE: if (rx_valid_q) begin
          // bit 7 selects write, low nibble is the address
          uart_we_o   <= rx_byte_q[7];
          uart_addr_o <= rx_byte_q[ADDR_W-1:0];
          cmd_q       <= rx_byte_q[7] ? C_DATA_HI : C_REQ;
        end
        C_DATA_HI: if (rx_valid_q) begin
          uart_wdata_o[15:8] <= rx_byte_q;
          cmd_q              <= C_DATA_LO;
        end
        C_DATA_LO: if (rx_valid_q) begin
          uart_wdata_o[7:0] <= rx_byte_q;
          cmd_q             <= C_REQ;
        end
        C_REQ: if (uart_gnt_i) begin
          cmd_q <= uart_we_o ? C_IDLE : C_READ;
        end
        C_READ: if (uart_rvalid_i) begin
          resp_q <= rd_data_i;
          cmd_q  <= C_TX_HI;
        end
        // high byte first, each waits for an idle transmitter
        C_TX_HI: if (!tx_busy_q) cmd_q <= C_TX_LO;
        C_TX_LO: if (!tx_busy_q) cmd_q <= C_IDLE;
        default: cmd_q <= C_IDLE;
      endcase
    end
  end

  assign uart_req_o = (cmd_q == C_REQ);
  assign tx_load    = ((cmd_q == C_TX_HI) || (cmd_q == C_TX_LO)) && !tx_busy_q;
  assign tx_byte    = (cmd_q == C_TX_HI) ? resp_q[15:8] : resp_q[7:0];

  // transmitter, stop bit shifted in from the top
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q  <= 1'b0;
      tx_cnt_q   <= '0;
      tx_bit_q   <= '0;
      tx_shift_q <= '1;
    end else if (tx_load) begin
      tx_busy_q  <= 1'b1;
      tx_cnt_q   <= UART_CNT_W'(UART_DIV - 1);
      tx_bit_q   <= '0;
      tx_shift_q <= {1'b1, tx_byte, 1'b0};
    end else if (tx_busy_q) begin
      if (tx_cnt_q != '0) begin
        tx_cnt_q <= tx_cnt_q - 1'b1;
      end else begin
        tx_cnt_q   <= UART_CNT_W'(UART_DIV - 1);
        tx_bit_q   <= tx_bit_q + 1'b1;
        tx_shift_q <= {1'b1, tx_shift_q[9:1]};
        // full stop bit sent
        if (tx_bit_q == 4'd9) begin
          tx_busy_q <= 1'b0;
        end
      end
    end
  end

  assign uart_tx_o = tx_shift_q[0];

endmodule

//--- testbench/soc_checker.sv
`timescale 1ns/100ps

module soc_checker (
  input  logic clock_i,
  input  logic arst_n_i,
  input  logic dbg_req_i,
  input  logic uart_req_i,
  input  logic dbg_gnt_i,
  input  logic uart_gnt_i,
  input  logic pwm_i
);

  // failing assertions, read back by the testbench at the end
  int fail_count = 0;

  // one grant per request, the master drops req right after it
  a_dbg_gnt_once: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    dbg_gnt_i |=> !dbg_req_i)
    else begin
      $error("dbg request still high after its grant");
      fail_count++;
    end

  a_uart_gnt_once: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    uart_gnt_i |=> !uart_req_i)
    else begin
      $error("uart request still high after its grant");
      fail_count++;
    end

  // loser of a contention is served in the following cycle
  a_dbg_wait_one: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    (dbg_req_i && !dbg_gnt_i) |=> dbg_gnt_i)
    else begin
      $error("dbg request waited more than one cycle for its grant");
      fail_count++;
    end

  a_uart_wait_one: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    (uart_req_i && !uart_gnt_i) |=> uart_gnt_i)
    else begin
      $error("uart request waited more than one cycle for its grant");
      fail_count++;
    end

  // first cycle out of reset is quiet
  a_reset_state: assert property (@(posedge clock_i)
    $rose(arst_n_i) |-> (!pwm_i && !dbg_req_i && !uart_req_i))
    else begin
      $error("pwm or requests active right after reset");
      fail_count++;
    end

endmodule

//--- testbench/soc_monitor.sv
`timescale 1ns/100ps

module soc_monitor import soc_pkg::*; (
  input  logic              clock_i,
  input  logic              uart_tx_i,
  input  logic [DATA_W-1:0] gpio_out_i,
  input  logic              pwm_i
);

  int errors = 0;
  // bytes decoded from the uart transmit line
  logic [7:0] rx_q[$];

  function automatic void compare(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endfunction

  function automatic void check_gpio(input logic [DATA_W-1:0] exp);
    compare("gpio_o", 32'(gpio_out_i), 32'(exp));
  endfunction

  // counts pwm high cycles over three periods once the counter has settled
  task automatic measure_pwm(input int period, input int duty);
    int high;
    high = 0;
    repeat (2 * (period + 1)) @(negedge clock_i);
    repeat (3 * (period + 1)) begin
      @(negedge clock_i);
      if (pwm_i) high++;
    end
    compare("pwm high cycles", 32'(high), 32'(3 * duty));
  endtask

  // uart decoder, sampled on the falling clock where the line is stable
  initial begin : uart_decode
    logic [7:0] b;
    forever begin
      @(negedge clock_i);
      if (uart_tx_i === 1'b0) begin
        // middle of the start bit
        repeat (UART_DIV / 2) @(negedge clock_i);
        for (int i = 0; i < 8; i++) begin
          repeat (UART_DIV) @(negedge clock_i);
          b[i] = uart_tx_i;
        end
        repeat (UART_DIV) @(negedge clock_i);
        if (uart_tx_i === 1'b1) begin
          rx_q.push_back(b);
        end else begin
          $display("FAILED %0t: uart_tx_o stop bit low", $time);
          errors++;
        end
      end
    end
  end

endmodule

//--- testbench/soc_tb.sv
`timescale 1ns/100ps

module soc_tb import soc_pkg::*; ();

  // clock_i cycles per tck phase, enough for the two-flop sync
  localparam int HALF_TCK   = 5;
  localparam int WAIT_LIMIT = 2000;
  // delays the uart command so both requests reach the arbiter together
  localparam int UART_LEAD  = 293;
  localparam int M_JTAG = 0;
  localparam int M_UART = 1;
  localparam int OP_IDCODE = 0;
  localparam int OP_WRITE  = 1;
  localparam int OP_READ   = 2;
  localparam int OP_GPIO   = 3;
  localparam int OP_BOTH   = 4;
  localparam int OP_PWM    = 5;

  typedef struct {
    int          master;
    int          op;
    logic [3:0]  addr;
    logic [15:0] data;
    logic [31:0] expected;
  } entry_t;

  logic              clock_i;
  logic              arst_n_i;
  logic [DATA_W-1:0] gpio_i;
  logic [DATA_W-1:0] gpio_o;
  logic              uart_rx_i;
  logic              uart_tx_o;
  logic              pwm_o;
  logic              jtag_tck_i;
  logic              jtag_tms_i;
  logic              jtag_tdi_i;
  logic              jtag_tdo_o;
  entry_t            stim[$];
  int                timeouts = 0;
  logic [15:0]       gpio_val;
  logic [15:0]       d1;
  logic [15:0]       d2;
  logic [15:0]       d3;

  soc_top DUT (.*);

  soc_monitor MON (
    .clock_i    (clock_i),
    .uart_tx_i  (uart_tx_o),
    .gpio_out_i (gpio_o),
    .pwm_i      (pwm_o)
  );

  bind soc_top soc_checker CHK (
    .clock_i    (clock_i),
    .arst_n_i   (arst_n_i),
    .dbg_req_i  (dbg_req),
    .uart_req_i (uart_req),
    .dbg_gnt_i  (dbg_gnt),
    .uart_gnt_i (uart_gnt),
    .pwm_i      (pwm_o)
  );

  initial begin
    clock_i = 1'b0;
    forever #20 clock_i = ~clock_i;
  end

  // whole-run limit
  initial begin
    #5ms;
    $display("simulation stopped: overall time limit reached");
    $display("Done: errors found");
    $finish;
  end

  task automatic cycles(input int n);
    repeat (n) @(posedge clock_i);
    #2;
  endtask

  // one tck period, tdo read just before the rising edge
  task automatic tck_bit(input logic tms, input logic tdi, output logic tdo);
    jtag_tck_i = 1'b0;
    jtag_tms_i = tms;
    jtag_tdi_i = tdi;
    cycles(HALF_TCK);
    tdo = jtag_tdo_o;
    jtag_tck_i = 1'b1;
    cycles(HALF_TCK);
  endtask

  task automatic jtag_reset();
    logic b;
    repeat (5) tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
  endtask

  // run-test-idle to run-test-idle through shift-ir
  task automatic scan_ir(input logic [IR_W-1:0] ir);
    logic b;
    tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
    for (int i = 0; i < IR_W; i++) tck_bit(i == IR_W - 1, ir[i], b);
    tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
  endtask

  task automatic scan_dr(input logic [31:0] din, input int n, output logic [31:0] dout);
    logic b;
    dout = '0;
    tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
    for (int i = 0; i < n; i++) begin
      tck_bit(i == n - 1, din[i], b);
      dout[i] = b;
    end
    tck_bit(1'b1, 1'b0, b);
    tck_bit(1'b0, 1'b0, b);
  endtask

  task automatic jtag_write(input logic [3:0] addr, input logic [15:0] data);
    logic [31:0] cap;
    scan_ir(IR_DBG);
    scan_dr(32'({addr, data, DBG_OP_WRITE}), DBG_W, cap);
  endtask

  // rescans until the captured op no longer shows busy
  task automatic jtag_read(input logic [3:0] addr, input logic [15:0] exp);
    logic [31:0] cap;
    int tries;
    scan_ir(IR_DBG);
    scan_dr(32'({addr, 16'h0, DBG_OP_READ}), DBG_W, cap);
    tries = 0;
    do begin
      scan_dr(32'({addr, 16'h0, DBG_OP_NONE}), DBG_W, cap);
      tries++;
    end while (cap[1:0] == DBG_OP_BUSY && tries < 8);
    if (cap[1:0] == DBG_OP_BUSY) begin
      $display("timeout: jtag debug read of address %0d stayed busy", addr);
      timeouts++;
    end else begin
      MON.compare("jtag debug read", cap, 32'({addr, exp, DBG_OP_NONE}));
    end
  endtask

  // 8N1, lsb first
  task automatic uart_send(input logic [7:0] b);
    uart_rx_i = 1'b0;
    cycles(UART_DIV);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = b[i];
      cycles(UART_DIV);
    end
    uart_rx_i = 1'b1;
    cycles(UART_DIV);
  endtask

  task automatic uart_write(input logic [3:0] addr, input logic [15:0] data);
    uart_send({4'b1000, addr});
    uart_send(data[15:8]);
    uart_send(data[7:0]);
  endtask

  task automatic uart_read(input logic [3:0] addr, input logic [15:0] exp);
    logic [15:0] word;
    int n;
    uart_send({4'b0000, addr});
    n = 0;
    while (MON.rx_q.size() < 2 && n < WAIT_LIMIT) begin
      cycles(1);
      n++;
    end
    if (MON.rx_q.size() < 2) begin
      $display("timeout: no uart response to read of address %0d", addr);
      timeouts++;
      MON.rx_q.delete();
    end else begin
      word[15:8] = MON.rx_q.pop_front();
      word[7:0]  = MON.rx_q.pop_front();
      MON.compare("uart read", 32'(word), 32'(exp));
    end
  endtask

  task automatic wait_gpio(input logic [15:0] exp);
    int n;
    n = 0;
    while (gpio_o !== exp && n < WAIT_LIMIT) begin
      cycles(1);
      n++;
    end
    MON.check_gpio(exp);
  endtask

  function automatic void add_entry(input int m, input int op, input logic [3:0] addr,
                                    input logic [15:0] data, input logic [31:0] exp);
    entry_t e;
    e = '{m, op, addr, data, exp};
    stim.push_back(e);
  endfunction

  initial begin
    arst_n_i   = 1'b0;
    gpio_i     = '0;
    uart_rx_i  = 1'b1;
    jtag_tck_i = 1'b0;
    jtag_tms_i = 1'b1;
    jtag_tdi_i = 1'b0;
    void'($urandom(17286));
    gpio_val = 16'($urandom);
    d1 = 16'($urandom);
    d2 = 16'($urandom);
    d3 = 16'($urandom);
    gpio_i = gpio_val;
    repeat (3) @(posedge clock_i);
    #2;
    arst_n_i = 1'b1;
    cycles(2);
    MON.compare("gpio_o after reset", 32'(gpio_o), 32'h0);
    MON.compare("uart_tx_o after reset", 32'(uart_tx_o), 32'h1);
    MON.compare("jtag_tdo_o after reset", 32'(jtag_tdo_o), 32'h0);

    // expected values follow the register map rules
    add_entry(M_JTAG, OP_IDCODE, 4'd0, 16'd0, JTAG_IDCODE);
    add_entry(M_JTAG, OP_WRITE, REG_GPIO_OUT, d1, 32'd0);
    add_entry(M_JTAG, OP_GPIO, REG_GPIO_OUT, 16'd0, 32'(d1));
    add_entry(M_JTAG, OP_READ, REG_GPIO_OUT, 16'd0, 32'(d1));
    add_entry(M_UART, OP_WRITE, REG_GPIO_OUT, d2, 32'd0);
    add_entry(M_UART, OP_GPIO, REG_GPIO_OUT, 16'd0, 32'(d2));
    add_entry(M_UART, OP_READ, REG_GPIO_IN, 16'd0, 32'(gpio_val));
    add_entry(M_UART, OP_READ, REG_ID, 16'd0, 32'(SOC_ID));
    add_entry(M_JTAG, OP_BOTH, REG_GPIO_OUT, 16'd0, 32'(d2));
    add_entry(M_JTAG, OP_WRITE, REG_PWM_PERIOD, 16'd9, 32'd0);
    add_entry(M_UART, OP_WRITE, REG_PWM_DUTY, 16'd4, 32'd0);
    add_entry(M_JTAG, OP_PWM, 4'd0, 16'd9, 32'd4);
    // gpio input is read only
    add_entry(M_UART, OP_WRITE, REG_GPIO_IN, d3, 32'd0);
    add_entry(M_UART, OP_GPIO, REG_GPIO_OUT, 16'd0, 32'(d2));
    add_entry(M_UART, OP_READ, REG_GPIO_IN, 16'd0, 32'(gpio_val));
    add_entry(M_JTAG, OP_READ, 4'hB, 16'd0, 32'd0);
    add_entry(M_UART, OP_READ, 4'hE, 16'd0, 32'd0);

    jtag_reset();
    foreach (stim[i]) begin
      case (stim[i].op)
        OP_IDCODE: begin
          logic [31:0] cap;
          scan_dr(32'h0, 32, cap);
          MON.compare("jtag idcode", cap, stim[i].expected);
        end
        OP_WRITE: begin
          if (stim[i].master == M_JTAG) jtag_write(stim[i].addr, stim[i].data);
          else uart_write(stim[i].addr, stim[i].data);
        end
        OP_READ: begin
          if (stim[i].master == M_JTAG) jtag_read(stim[i].addr, stim[i].expected[15:0]);
          else uart_read(stim[i].addr, stim[i].expected[15:0]);
        end
        OP_GPIO: wait_gpio(stim[i].expected[15:0]);
        OP_BOTH: begin
          fork
            jtag_read(stim[i].addr, stim[i].expected[15:0]);
            begin
              cycles(UART_LEAD);
              uart_read(stim[i].addr, stim[i].expected[15:0]);
            end
          join
        end
        OP_PWM: begin
          MON.measure_pwm(int'(stim[i].data), int'(stim[i].expected));
          cycles(1);
        end
        default: begin
          $display("unknown table operation in entry %0d", i);
          MON.errors++;
        end
      endcase
    end

    cycles(4);
    $display("check errors: %0d, timeouts: %0d, assertion failures: %0d",
             MON.errors, timeouts, DUT.CHK.fail_count);
    if (MON.errors == 0 && timeouts == 0 && DUT.CHK.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
